// File: common/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int ADDR_W  = 32;
    localparam int INST_W  = 32;
    localparam int DATA_W  = 32;
    localparam int REG_W   = 5;
    localparam int ALUOP_W = 8;
    localparam int ECODE_W = 7;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INST_W-1:0]  inst_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [REG_W-1:0]   reg_addr_t;
    typedef logic [ALUOP_W-1:0] aluop_t;
    typedef logic [ECODE_W-1:0] ecode_t;

    localparam aluop_t ALU_NOP = 8'h00;
    localparam aluop_t ALU_ADD = 8'h01; // add.w and addi.w
    localparam aluop_t ALU_SUB = 8'h02;
    localparam aluop_t ALU_AND = 8'h03;
    localparam aluop_t ALU_OR  = 8'h04;
    localparam aluop_t ALU_XOR = 8'h05;
    localparam aluop_t ALU_MUL = 8'h06;
    localparam aluop_t ALU_DIV = 8'h07;
    localparam aluop_t ALU_LUI = 8'h08;

    // three-register forms match inst[31:15]
    localparam logic [16:0] OP3R_ADD = 17'h00020;
    localparam logic [16:0] OP3R_SUB = 17'h00022;
    localparam logic [16:0] OP3R_AND = 17'h00029;
    localparam logic [16:0] OP3R_OR  = 17'h0002A;
    localparam logic [16:0] OP3R_XOR = 17'h0002B;
    localparam logic [16:0] OP3R_MUL = 17'h00038;
    localparam logic [16:0] OP3R_DIV = 17'h00040;
    localparam logic [9:0]  OP_ADDI  = 10'h00A;    // inst[31:22]
    localparam logic [6:0]  OP_LU12I = 7'h0A;      // inst[31:25]

    localparam ecode_t ECODE_INE = 7'h0D;          // instruction not exist

    localparam int F_PC    = 0;
    localparam int F_OP    = F_PC + ADDR_W;
    localparam int F_IMM   = F_OP + ALUOP_W;
    localparam int F_RJ_EN = F_IMM + DATA_W;
    localparam int F_RK_EN = F_RJ_EN + 1;
    localparam int F_RJ    = F_RK_EN + 1;
    localparam int F_RK    = F_RJ + REG_W;
    localparam int F_WE    = F_RK + REG_W;
    localparam int F_RD    = F_WE + 1;
    localparam int F_MUL   = F_RD + REG_W;
    localparam int F_DIV   = F_MUL + 1;
    localparam int F_EXCP  = F_DIV + 1;
    localparam int F_ECODE = F_EXCP + 1;
    localparam int ENTRY_W = F_ECODE + ECODE_W;    // valid bit lives outside the entry

    typedef logic [ENTRY_W-1:0] entry_t;

endpackage

`default_nettype wire

// File: design/id_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module id_decoder (
    input  wire decode_pkg::addr_t  pc_i,
    input  wire decode_pkg::inst_t  inst_i,
    input  wire                     fetch_excp_i,
    input  wire decode_pkg::ecode_t fetch_ecode_i,
    output decode_pkg::entry_t      entry_o
);

    logic [16:0] op_3r;
    logic [9:0]  op_2ri12;
    logic [6:0]  op_1ri20;

    decode_pkg::reg_addr_t rj;
    decode_pkg::reg_addr_t rk;
    decode_pkg::reg_addr_t rd;

    decode_pkg::aluop_t aluop;
    decode_pkg::data_t  imm;
    decode_pkg::ecode_t ecode;
    logic               rj_en;
    logic               rk_en;
    logic               we;
    logic               is_mul;
    logic               is_div;
    logic               is_3r;
    logic               known;      // encoding is in the supported set
    logic               excp;

    assign op_3r    = inst_i[31:15];
    assign op_2ri12 = inst_i[31:22];
    assign op_1ri20 = inst_i[31:25];

    assign rd = inst_i[4:0];
    assign rj = inst_i[9:5];
    assign rk = inst_i[14:10];

    always_comb begin
        aluop  = decode_pkg::ALU_NOP;
        imm    = '0;
        rj_en  = 1'b0;
        rk_en  = 1'b0;
        we     = 1'b0;
        is_mul = 1'b0;
        is_div = 1'b0;
        is_3r  = 1'b1;
        known  = 1'b1;

        case (op_3r)
            decode_pkg::OP3R_ADD: aluop = decode_pkg::ALU_ADD;
            decode_pkg::OP3R_SUB: aluop = decode_pkg::ALU_SUB;
            decode_pkg::OP3R_AND: aluop = decode_pkg::ALU_AND;
            decode_pkg::OP3R_OR:  aluop = decode_pkg::ALU_OR;
            decode_pkg::OP3R_XOR: aluop = decode_pkg::ALU_XOR;
            decode_pkg::OP3R_MUL: begin
                aluop  = decode_pkg::ALU_MUL;
                is_mul = 1'b1;
            end
            decode_pkg::OP3R_DIV: begin
                aluop  = decode_pkg::ALU_DIV;
                is_div = 1'b1;
            end
            default: is_3r = 1'b0;
        endcase

        if (is_3r) begin
            rj_en = 1'b1;
            rk_en = 1'b1;
            we    = 1'b1;       // set even for rd == 0
        end else if (op_2ri12 == decode_pkg::OP_ADDI) begin
            aluop = decode_pkg::ALU_ADD;
            imm   = {{20{inst_i[21]}}, inst_i[21:10]};  // si12
            rj_en = 1'b1;
            we    = 1'b1;
        end else if (op_1ri20 == decode_pkg::OP_LU12I) begin
            aluop = decode_pkg::ALU_LUI;
            imm   = {inst_i[24:5], 12'h000};
            we    = 1'b1;
        end else begin
            known = 1'b0;       // falls to INE
        end
    end

    // fetch fault outranks INE while the decoded fields stay as formed
    assign excp  = fetch_excp_i | ~known;
    assign ecode = fetch_excp_i ? fetch_ecode_i :
                   (known ? '0 : decode_pkg::ECODE_INE);

    always_comb begin
        entry_o[decode_pkg::F_PC +: decode_pkg::ADDR_W]     = pc_i;
        entry_o[decode_pkg::F_OP +: decode_pkg::ALUOP_W]    = aluop;
        entry_o[decode_pkg::F_IMM +: decode_pkg::DATA_W]    = imm;
        entry_o[decode_pkg::F_RJ_EN]                        = rj_en;
        entry_o[decode_pkg::F_RK_EN]                        = rk_en;
        entry_o[decode_pkg::F_RJ +: decode_pkg::REG_W]      = rj;
        entry_o[decode_pkg::F_RK +: decode_pkg::REG_W]      = rk;
        entry_o[decode_pkg::F_WE]                           = we;
        entry_o[decode_pkg::F_RD +: decode_pkg::REG_W]      = rd;
        entry_o[decode_pkg::F_MUL]                          = is_mul;
        entry_o[decode_pkg::F_DIV]                          = is_div;
        entry_o[decode_pkg::F_EXCP]                         = excp;
        entry_o[decode_pkg::F_ECODE +: decode_pkg::ECODE_W] = ecode;
    end

endmodule

`default_nettype wire

// File: design/inst_queue.sv
`timescale 1ns/10ps
`default_nettype none

module inst_queue #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 64
) (
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              flush_i,
    input  wire [1:0]        push_i,
    input  wire [WIDTH-1:0]  push_data_1_i,
    input  wire [WIDTH-1:0]  push_data_2_i,
    input  wire [1:0]        pop_i,
    output logic [1:0]       head_valid_o,
    output logic [WIDTH-1:0] head_data_1_o,
    output logic [WIDTH-1:0] head_data_2_o,
    output logic             stall_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    if (DEPTH < 4 || (DEPTH & (DEPTH - 1)) != 0) begin : g_bad_depth
        $error("inst_queue: DEPTH must be a power of two and at least 4");
    end

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_ptr_2;     // slot for lane 2
    logic [PTR_W-1:0] rd_ptr_1;     // second head
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] n_push;
    logic [CNT_W-1:0] n_pop;

    assign n_push = CNT_W'(push_i[0]) + CNT_W'(push_i[1]);
    assign n_pop  = CNT_W'(pop_i[0]) + CNT_W'(pop_i[1]);

    // a lone lane 2 lands at wr_ptr, keeping the queue dense
    assign wr_ptr_2 = wr_ptr + PTR_W'(push_i[0]);
    assign rd_ptr_1 = rd_ptr + PTR_W'(1);

    always_ff @(posedge clk) begin
        if (push_i[0])
            mem[wr_ptr] <= push_data_1_i;
        if (push_i[1])
            mem[wr_ptr_2] <= push_data_2_i;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            rd_ptr <= '0;           // beats push and pop
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(n_pop);
            wr_ptr <= wr_ptr + PTR_W'(n_push);
            count  <= count + n_push - n_pop;
        end
    end

    assign head_valid_o[0] = (count != '0);
    assign head_valid_o[1] = (count > CNT_W'(1));
    assign head_data_1_o   = mem[rd_ptr];
    assign head_data_2_o   = mem[rd_ptr_1];

    // fewer than two free slots
    assign stall_o = (count > CNT_W'(DEPTH - 2));

    a_pop_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(pop_i[1] && !pop_i[0]))
        else $error("inst_queue: head 1 acked without head 0");

    a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        (pop_i & ~head_valid_o) == 2'b00)
        else $error("inst_queue: ack on an empty head");

    a_push_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |-> (push_i == 2'b00))
        else $error("inst_queue: push while stalled");

    // must still hold one cycle after any push/pop mix
    a_count_max: assert property (@(posedge clk) disable iff (!rst_n_i)
        count <= CNT_W'(DEPTH))
        else $error("inst_queue: occupancy above DEPTH");

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          flush_i,
    input  wire                          valid_1_i,
    input  wire                          valid_2_i,
    input  wire decode_pkg::addr_t       pc_1_i,
    input  wire decode_pkg::addr_t       pc_2_i,
    input  wire decode_pkg::inst_t       inst_1_i,
    input  wire decode_pkg::inst_t       inst_2_i,
    input  wire                          fetch_excp_1_i,
    input  wire                          fetch_excp_2_i,
    input  wire decode_pkg::ecode_t      fetch_ecode_1_i,
    input  wire decode_pkg::ecode_t      fetch_ecode_2_i,
    input  wire [1:0]                    issue_ack_i,
    output logic                         decode_stall_o,
    output logic [1:0]                   issue_valid_o,
    output decode_pkg::addr_t            issue_pc_1_o,
    output decode_pkg::aluop_t           issue_aluop_1_o,
    output decode_pkg::data_t            issue_imm_1_o,
    output logic                         issue_rj_en_1_o,
    output logic                         issue_rk_en_1_o,
    output decode_pkg::reg_addr_t        issue_rj_1_o,
    output decode_pkg::reg_addr_t        issue_rk_1_o,
    output logic                         issue_we_1_o,
    output decode_pkg::reg_addr_t        issue_rd_1_o,
    output logic                         issue_mul_1_o,
    output logic                         issue_div_1_o,
    output logic                         issue_excp_1_o,
    output decode_pkg::ecode_t           issue_ecode_1_o,
    output decode_pkg::addr_t            issue_pc_2_o,
    output decode_pkg::aluop_t           issue_aluop_2_o,
    output decode_pkg::data_t            issue_imm_2_o,
    output logic                         issue_rj_en_2_o,
    output logic                         issue_rk_en_2_o,
    output decode_pkg::reg_addr_t        issue_rj_2_o,
    output decode_pkg::reg_addr_t        issue_rk_2_o,
    output logic                         issue_we_2_o,
    output decode_pkg::reg_addr_t        issue_rd_2_o,
    output logic                         issue_mul_2_o,
    output logic                         issue_div_2_o,
    output logic                         issue_excp_2_o,
    output decode_pkg::ecode_t           issue_ecode_2_o
);

    decode_pkg::entry_t dec_entry_1;
    decode_pkg::entry_t dec_entry_2;
    decode_pkg::entry_t head_1;
    decode_pkg::entry_t head_2;
    logic [1:0]         push;
    logic               stall;

    id_decoder u_id_1 (
        .pc_i          (pc_1_i),
        .inst_i        (inst_1_i),
        .fetch_excp_i  (fetch_excp_1_i),
        .fetch_ecode_i (fetch_ecode_1_i),
        .entry_o       (dec_entry_1)
    );

    id_decoder u_id_2 (
        .pc_i          (pc_2_i),
        .inst_i        (inst_2_i),
        .fetch_excp_i  (fetch_excp_2_i),
        .fetch_ecode_i (fetch_ecode_2_i),
        .entry_o       (dec_entry_2)
    );

    assign push = {valid_2_i, valid_1_i} & {2{~stall}};    // fetch holds while stalled

    inst_queue #(
        .DEPTH (QUEUE_DEPTH),
        .WIDTH (decode_pkg::ENTRY_W)
    ) u_queue (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .push_i        (push),
        .push_data_1_i (dec_entry_1),
        .push_data_2_i (dec_entry_2),
        .pop_i         (issue_ack_i),
        .head_valid_o  (issue_valid_o),
        .head_data_1_o (head_1),
        .head_data_2_o (head_2),
        .stall_o       (stall)
    );

    assign decode_stall_o = stall;

    assign issue_pc_1_o    = head_1[decode_pkg::F_PC +: decode_pkg::ADDR_W];
    assign issue_aluop_1_o = head_1[decode_pkg::F_OP +: decode_pkg::ALUOP_W];
    assign issue_imm_1_o   = head_1[decode_pkg::F_IMM +: decode_pkg::DATA_W];
    assign issue_rj_en_1_o = head_1[decode_pkg::F_RJ_EN];
    assign issue_rk_en_1_o = head_1[decode_pkg::F_RK_EN];
    assign issue_rj_1_o    = head_1[decode_pkg::F_RJ +: decode_pkg::REG_W];
    assign issue_rk_1_o    = head_1[decode_pkg::F_RK +: decode_pkg::REG_W];
    assign issue_we_1_o    = head_1[decode_pkg::F_WE];
    assign issue_rd_1_o    = head_1[decode_pkg::F_RD +: decode_pkg::REG_W];
    assign issue_mul_1_o   = head_1[decode_pkg::F_MUL];
    assign issue_div_1_o   = head_1[decode_pkg::F_DIV];
    assign issue_excp_1_o  = head_1[decode_pkg::F_EXCP];
    assign issue_ecode_1_o = head_1[decode_pkg::F_ECODE +: decode_pkg::ECODE_W];

    assign issue_pc_2_o    = head_2[decode_pkg::F_PC +: decode_pkg::ADDR_W];
    assign issue_aluop_2_o = head_2[decode_pkg::F_OP +: decode_pkg::ALUOP_W];
    assign issue_imm_2_o   = head_2[decode_pkg::F_IMM +: decode_pkg::DATA_W];
    assign issue_rj_en_2_o = head_2[decode_pkg::F_RJ_EN];
    assign issue_rk_en_2_o = head_2[decode_pkg::F_RK_EN];
    assign issue_rj_2_o    = head_2[decode_pkg::F_RJ +: decode_pkg::REG_W];
    assign issue_rk_2_o    = head_2[decode_pkg::F_RK +: decode_pkg::REG_W];
    assign issue_we_2_o    = head_2[decode_pkg::F_WE];
    assign issue_rd_2_o    = head_2[decode_pkg::F_RD +: decode_pkg::REG_W];
    assign issue_mul_2_o   = head_2[decode_pkg::F_MUL];
    assign issue_div_2_o   = head_2[decode_pkg::F_DIV];
    assign issue_excp_2_o  = head_2[decode_pkg::F_EXCP];
    assign issue_ecode_2_o = head_2[decode_pkg::F_ECODE +: decode_pkg::ECODE_W];

endmodule

`default_nettype wire

// File: test/tb_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage;

    typedef string word_q_t[$];

    logic        clk;
    logic        rst_n_i;
    logic        flush_i;
    logic        valid_1_i;
    logic        valid_2_i;
    logic [31:0] pc_1_i;
    logic [31:0] pc_2_i;
    logic [31:0] inst_1_i;
    logic [31:0] inst_2_i;
    logic        fetch_excp_1_i;
    logic        fetch_excp_2_i;
    logic [6:0]  fetch_ecode_1_i;
    logic [6:0]  fetch_ecode_2_i;
    logic [1:0]  issue_ack_i;

    wire         decode_stall_o;
    wire  [1:0]  issue_valid_o;
    wire  [31:0] issue_pc_1_o, issue_pc_2_o, issue_imm_1_o, issue_imm_2_o;
    wire  [7:0]  issue_aluop_1_o, issue_aluop_2_o;
    wire  [4:0]  issue_rj_1_o, issue_rj_2_o, issue_rk_1_o, issue_rk_2_o;
    wire  [4:0]  issue_rd_1_o, issue_rd_2_o;
    wire  [6:0]  issue_ecode_1_o, issue_ecode_2_o;
    wire         issue_rj_en_1_o, issue_rj_en_2_o, issue_rk_en_1_o, issue_rk_en_2_o;
    wire         issue_we_1_o, issue_we_2_o, issue_mul_1_o, issue_mul_2_o;
    wire         issue_div_1_o, issue_div_2_o, issue_excp_1_o, issue_excp_2_o;

    string       trace_lines[$];
    int          cycles;
    int          limit;
    logic [31:0] act_1[13];
    logic [31:0] act_2[13];
    string       field_name[13] = '{"pc", "aluop", "imm", "rj_en", "rk_en", "rj", "rk",
                                    "we", "rd", "mul", "div", "excp", "ecode"};

    decode_stage #(.QUEUE_DEPTH(8)) decode_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_q_t split_words(input string s);
        word_q_t words;
        int      start;
        byte     c;
        start = -1;
        for (int i = 0; i <= s.len(); i++) begin
            c = (i < s.len()) ? s.getc(i) : 8'h20;
            if (c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d) begin
                if (start >= 0)
                    words.push_back(s.substr(start, i - 1));
                start = -1;
            end else if (start < 0) begin
                start = i;
            end
        end
        return words;
    endfunction

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", name, field,
                     expected, actual);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic capture_outputs();
        act_1[0]  = issue_pc_1_o;
        act_1[1]  = 32'(issue_aluop_1_o);
        act_1[2]  = issue_imm_1_o;
        act_1[3]  = 32'(issue_rj_en_1_o);
        act_1[4]  = 32'(issue_rk_en_1_o);
        act_1[5]  = 32'(issue_rj_1_o);
        act_1[6]  = 32'(issue_rk_1_o);
        act_1[7]  = 32'(issue_we_1_o);
        act_1[8]  = 32'(issue_rd_1_o);
        act_1[9]  = 32'(issue_mul_1_o);
        act_1[10] = 32'(issue_div_1_o);
        act_1[11] = 32'(issue_excp_1_o);
        act_1[12] = 32'(issue_ecode_1_o);
        act_2[0]  = issue_pc_2_o;
        act_2[1]  = 32'(issue_aluop_2_o);
        act_2[2]  = issue_imm_2_o;
        act_2[3]  = 32'(issue_rj_en_2_o);
        act_2[4]  = 32'(issue_rk_en_2_o);
        act_2[5]  = 32'(issue_rj_2_o);
        act_2[6]  = 32'(issue_rk_2_o);
        act_2[7]  = 32'(issue_we_2_o);
        act_2[8]  = 32'(issue_rd_2_o);
        act_2[9]  = 32'(issue_mul_2_o);
        act_2[10] = 32'(issue_div_2_o);
        act_2[11] = 32'(issue_excp_2_o);
        act_2[12] = 32'(issue_ecode_2_o);
    endtask

    task automatic drive_inputs(input word_q_t w);
        valid_1_i       <= w[1].atohex() != 0;
        valid_2_i       <= w[2].atohex() != 0;
        pc_1_i          <= 32'(w[3].atohex());
        inst_1_i        <= 32'(w[4].atohex());
        fetch_excp_1_i  <= w[5].atohex() != 0;
        fetch_ecode_1_i <= 7'(w[6].atohex());
        pc_2_i          <= 32'(w[7].atohex());
        inst_2_i        <= 32'(w[8].atohex());
        fetch_excp_2_i  <= w[9].atohex() != 0;
        fetch_ecode_2_i <= 7'(w[10].atohex());
        flush_i         <= w[11].atohex() != 0;
        issue_ack_i     <= 2'(w[12].atohex());
    endtask

    task automatic check_outputs(input word_q_t w);
        logic [31:0] exp_valid;
        exp_valid = 32'(w[14].atohex());
        capture_outputs();
        check_value(w[0], "stall", 32'(w[13].atohex()), 32'(decode_stall_o));
        check_value(w[0], "valid", exp_valid, 32'(issue_valid_o));
        for (int k = 0; k < 13; k++) begin
            if (exp_valid[0])
                check_value(w[0], {"head0 ", field_name[k]}, 32'(w[15 + k].atohex()), act_1[k]);
            if (exp_valid[1])
                check_value(w[0], {"head1 ", field_name[k]}, 32'(w[28 + k].atohex()), act_2[k]);
        end
    endtask

    // cycle budget armed once the trace length is known
    initial begin
        cycles = 0;
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: trace did not finish within %0d cycles", limit);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin : replay
        int      fd;
        string   line;
        word_q_t words;
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        valid_1_i       = 1'b0;
        valid_2_i       = 1'b0;
        pc_1_i          = '0;
        pc_2_i          = '0;
        inst_1_i        = '0;
        inst_2_i        = '0;
        fetch_excp_1_i  = 1'b0;
        fetch_excp_2_i  = 1'b0;
        fetch_ecode_1_i = '0;
        fetch_ecode_2_i = '0;
        issue_ack_i     = '0;
        limit           = 0;

        fd = $fopen("test/decode_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file test/decode_trace.txt");
            $display("** FAIL **");
            $fatal(1, "missing trace");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            words = split_words(line);
            if (words.size() != 0 && words[0].getc(0) != "#") begin
                if (words.size() != 41) begin
                    $display("trace line has %0d fields instead of 41: %s",
                             words.size(), line);
                    $display("** FAIL **");
                    $fatal(1, "malformed trace");
                end
                trace_lines.push_back(line);
            end
        end
        $fclose(fd);
        limit = trace_lines.size() + 50;

        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;

        foreach (trace_lines[i]) begin
            words = split_words(trace_lines[i]);
            @(posedge clk);
            drive_inputs(words);
            @(negedge clk);     // heads have settled by mid-cycle
            check_outputs(words);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/decode_trace.txt
# name v1 v2 pc1 inst1 fe1 ec1 pc2 inst2 fe2 ec2 flush ack, then expected stall valid
# then head0 and head1: pc aluop imm rj_en rk_en rj rk we rd mul div excp ecode (hex)
add_sub 1 1 1000 00100c41 0 0 1004 001118a4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
and_or 1 1 1008 0014a507 0 0 100c 00150820 0 0 0 3 0 3 1000 1 0 1 1 2 3 1 1 0 0 0 0 1004 2 0 1 1 5 6 1 4 0 0 0 0
xor_mul 1 1 1010 0015b16a 0 0 1014 001c3dcd 0 0 0 3 0 3 1008 3 0 1 1 8 9 1 7 0 0 0 0 100c 4 0 1 1 1 2 1 0 0 0 0 0
div_addi 1 1 1018 00204a30 0 0 101c 02bffc62 0 0 0 3 0 3 1010 5 0 1 1 b c 1 a 0 0 0 0 1014 6 0 1 1 e f 1 d 1 0 0 0
lui_unk 1 1 1020 142468a5 0 0 1024 0 0 0 0 3 0 3 1018 7 0 1 1 11 12 1 10 0 1 0 0 101c 1 ffffffff 1 0 3 1f 1 2 0 0 0 0
fetch_excp 1 1 1028 0 1 8 102c 00100c41 1 9 0 3 0 3 1020 8 12345000 0 0 5 1a 1 5 0 0 0 0 1024 0 0 0 0 0 0 0 0 0 0 1 d
lane2_only 0 1 0 0 0 0 1030 001118a4 0 0 0 3 0 3 1028 0 0 0 0 0 0 0 0 0 0 1 8 102c 1 0 1 1 2 3 1 1 0 0 1 9
pair_ack_one 1 1 1034 0014a507 0 0 1038 00150820 0 0 0 1 0 1 1030 2 0 1 1 5 6 1 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
ack_head0 0 0 0 0 0 0 0 0 0 0 0 1 0 3 1034 3 0 1 1 8 9 1 7 0 0 0 0 1038 4 0 1 1 1 2 1 0 0 0 0 0
head1_moved 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1038 4 0 1 1 1 2 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
fill_1 1 1 1040 00100c41 0 0 1044 001118a4 0 0 0 0 0 1 1038 4 0 1 1 1 2 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
fill_2 1 1 1048 0014a507 0 0 104c 00150820 0 0 0 0 0 3 1038 4 0 1 1 1 2 1 0 0 0 0 0 1040 1 0 1 1 2 3 1 1 0 0 0 0
fill_3 1 1 1050 0015b16a 0 0 1054 001c3dcd 0 0 0 0 0 3 1038 4 0 1 1 1 2 1 0 0 0 0 0 1040 1 0 1 1 2 3 1 1 0 0 0 0
stall_hold 1 1 1058 00204a30 0 0 105c 02bffc62 0 0 0 0 1 3 1038 4 0 1 1 1 2 1 0 0 0 0 0 1040 1 0 1 1 2 3 1 1 0 0 0 0
stall_ack 1 1 1058 00204a30 0 0 105c 02bffc62 0 0 0 3 1 3 1038 4 0 1 1 1 2 1 0 0 0 0 0 1040 1 0 1 1 2 3 1 1 0 0 0 0
stall_drop 1 1 1058 00204a30 0 0 105c 02bffc62 0 0 0 3 0 3 1044 2 0 1 1 5 6 1 4 0 0 0 0 1048 3 0 1 1 8 9 1 7 0 0 0 0
drain_1 0 0 0 0 0 0 0 0 0 0 0 3 0 3 104c 4 0 1 1 1 2 1 0 0 0 0 0 1050 5 0 1 1 b c 1 a 0 0 0 0
drain_2 0 0 0 0 0 0 0 0 0 0 0 3 0 3 1054 6 0 1 1 e f 1 d 1 0 0 0 1058 7 0 1 1 11 12 1 10 0 1 0 0
flush 1 1 1060 142468a5 0 0 1064 0 0 0 1 0 0 1 105c 1 ffffffff 1 0 3 1f 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
post_flush 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
still_empty 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: vlog.f
common/decode_pkg.sv
design/id_decoder.sv
design/inst_queue.sv
design/decode_stage.sv
test/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_decode_stage -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
